/* dv/spi_flash_model.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_flash_model #(
    parameter int CPOL = 1,
    parameter int CPHA = 1
) (
    input  logic         sclk,
    input  logic         ss,
    input  logic         mosi,
    output logic         miso,
    input  logic [31:0]  miso_word,      // Read data, sent MSB first
    input  logic [7:0]   skip_periods,   // Command, address and dummy periods
    input  logic [5:0]   rx_bits,
    output logic [127:0] rec_bits,       // MOSI samples, oldest in the upper bits
    output logic [7:0]   rec_cnt,
    output logic [8:0]   edge_cnt
);

    localparam logic IDLE_LEVEL = (CPOL != 0);

    logic         miso_q     = 1'b0;
    logic [127:0] rec_q      = '0;
    logic [7:0]   cnt_q      = '0;
    logic [8:0]   edges_q    = '0;
    logic [7:0]   launch_idx = '0;   // Bit period of the next MISO launch
    logic         prev_sclk  = IDLE_LEVEL;
    logic         is_lead;

    assign miso     = miso_q;
    assign rec_bits = rec_q;
    assign rec_cnt  = cnt_q;
    assign edge_cnt = edges_q;

    // MISO level for a given bit period of the frame
    function automatic logic read_bit(input logic [7:0] period);
        int pos;
        pos = int'(period) - int'(skip_periods);
        if (pos >= 0 && pos < int'(rx_bits))
            return miso_word[31 - pos];
        return 1'b0;
    endfunction

    always @(negedge ss or posedge sclk or negedge sclk) begin
        if (sclk === prev_sclk) begin
            // Chip select fell, new frame
            rec_q   = '0;
            cnt_q   = '0;
            edges_q = '0;
            if (CPHA == 0) begin
                miso_q     = read_bit(8'd0);   // First bit ahead of any edge
                launch_idx = 8'd1;
            end else begin
                miso_q     = 1'b0;
                launch_idx = 8'd0;
            end
        end else if (ss === 1'b0) begin
            edges_q = edges_q + 1'b1;
            is_lead = (sclk != IDLE_LEVEL);
            if (is_lead == (CPHA == 0)) begin
                rec_q = {rec_q[126:0], mosi};   // Sample edge
                cnt_q = cnt_q + 1'b1;
            end else begin
                miso_q     = read_bit(launch_idx);
                launch_idx = launch_idx + 1'b1;
            end
        end
        prev_sclk = sclk;
    end

endmodule

`default_nettype wire

/* dv/spi_stimulus.txt */
// kind cmd address data_in nbits dummy miso_word tx_bits data_out, all hex
// Kinds 0 cmd, 1 read, 2 addr read, 3 write, 4 addr write, 5 addr; kind ff ends the list
0 06 000000 00000000 08 0 a5a5a5a5 08 00000000
1 9f 000000 00000000 18 0 c22017ff 08 00c22017
2 03 012345 00000000 20 0 deadbeef 20 deadbeef
2 0b abcdef 00000000 10 4 1234ffff 20 00001234
2 0b fedcba 00000000 0c f 9abcdef0 20 000009ab
3 01 000000 80000000 01 0 ffffffff 09 00000000
3 31 000000 c3a50000 10 0 00000000 18 00000000
4 02 000100 11223344 20 0 ffffffff 40 00000000
4 32 7fffff f0000000 04 3 0f0f0f0f 24 00000000
5 20 123456 00000000 08 0 ffffffff 20 00000000
5 d8 ff0000 ffffffff 20 7 aaaaaaaa 20 00000000
1 05 000000 00000000 08 0 5a000000 08 0000005a
1 35 000000 00000000 01 0 80000000 08 00000001
1 4b 000000 00000000 20 0 0f1e2d3c 08 0f1e2d3c
2 eb 000000 00000000 01 8 7fffffff 20 00000000
2 0b 00ff00 00000000 20 f 13579bdf 20 13579bdf
2 6b 5a5a5a 00000000 07 4 fe000000 20 0000007f
0 b9 000000 00000000 01 0 ffffffff 08 00000000
7 ab 000000 00000000 10 0 ffffffff 08 00000000
ff 00 000000 00000000 00 0 00000000 00 00000000

/* dv/tb_spi_flash_master.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_spi_flash_master;
    import spi_flash_pkg::*;

    localparam int          CLKS_PER_HALF = 2;
    localparam int          CPOL          = 1;
    localparam int          CPHA          = 1;
    localparam int          RESET_CYCLES  = 10;
    localparam int          FIELDS        = 9;     // Words per stimulus line
    localparam int          MAX_REQ       = 64;
    localparam int          WAIT_LIMIT    = 1000;
    localparam int          HOLD_CYCLES   = 50;
    localparam logic [31:0] END_MARK      = 32'hff;
    localparam int          SEL_READY     = 0;
    localparam int          SEL_SS        = 1;

    logic              clk;
    logic              rst;
    spi_req_t          req;
    logic              valid;
    logic              ready;
    logic              done;
    logic [DATA_W-1:0] data_out;
    logic              sclk;
    logic              ss;
    logic              mosi;
    logic              miso;
    logic [31:0]       miso_word;
    logic [7:0]        skip_periods;
    logic [5:0]        rx_bits;
    logic [127:0]      rec_bits;
    logic [7:0]        rec_cnt;
    logic [8:0]        edge_cnt;

    logic [31:0] stim [0:MAX_REQ*FIELDS-1];
    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    int          stim_errors;
    int          done_pulses;

    spi_flash_master #(
        .CLKS_PER_HALF_SCLK (CLKS_PER_HALF),
        .CPOL               (CPOL),
        .CPHA               (CPHA)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .valid    (valid),
        .ready    (ready),
        .done     (done),
        .data_out (data_out),
        .sclk     (sclk),
        .ss       (ss),
        .mosi     (mosi),
        .miso     (miso)
    );

    spi_flash_model #(
        .CPOL (CPOL),
        .CPHA (CPHA)
    ) u_flash (
        .sclk         (sclk),
        .ss           (ss),
        .mosi         (mosi),
        .miso         (miso),
        .miso_word    (miso_word),
        .skip_periods (skip_periods),
        .rx_bits      (rx_bits),
        .rec_bits     (rec_bits),
        .rec_cnt      (rec_cnt),
        .edge_cnt     (edge_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Shift the top count bits of word into acc MSB first
    function automatic logic [127:0] append_msb(input logic [127:0] acc,
                                                input logic [31:0] word, input int count);
        logic [127:0] res;
        res = acc;
        for (int i = 0; i < count; i++)
            res = {res[126:0], word[31-i]};
        return res;
    endfunction

    function automatic logic level_of(input int sel);
        case (sel)
            SEL_READY: return ready;
            default:   return ss;
        endcase
    endfunction

    // One clock with outputs sampled on the falling edge
    task automatic tick();
        @(negedge clk);
        if (done)
            done_pulses++;
    endtask

    task automatic wait_level(input int sel, input logic level, input string what,
                              output int cycles, output bit ok);
        cycles = 0;
        ok = 1'b1;
        while (level_of(sel) != level) begin
            if (cycles >= WAIT_LIMIT) begin
                ok = 1'b0;
                timeouts++;
                $display("Timed out after %0d cycles waiting for %s", cycles, what);
                return;
            end
            tick();
            cycles++;
        end
    endtask

    task automatic check_idle();
        assert (ss == 1'b1 && sclk == 1'(CPOL) && ready == 1'b1 && done == 1'b0
                && mosi == 1'b0) else begin
            errors++;
            $display("ERR %0t: after reset ss=%b sclk=%b ready=%b done=%b mosi=%b",
                     $time, ss, sclk, ready, done, mosi);
        end
    endtask

    task automatic run_request(input int idx, output bit ok);
        int           base;
        int           cycles;
        int           tx_len;
        int           dummy_n;
        int           rx_n;
        int           periods;
        int           pulses_before;
        int           ss_drops;
        int           gap;
        logic [2:0]   kind;
        logic [127:0] exp_bits;
        logic [31:0]  exp_dout;
        bit           has_addr;
        bit           writes;
        bit           reads;

        base = idx * FIELDS;
        kind = stim[base][2:0];
        req.kind         = spi_kind_t'(kind);
        req.command      = stim[base+1][7:0];
        req.address      = stim[base+2][23:0];
        req.data_in      = stim[base+3];
        req.nbits        = stim[base+4][5:0];
        req.dummy_cycles = stim[base+5][3:0];

        // Unknown kind codes match none of these and act as command only
        has_addr = (kind == 3'd2) || (kind == 3'd4) || (kind == 3'd5);
        writes   = (kind == 3'd3) || (kind == 3'd4);
        reads    = (kind == 3'd1) || (kind == 3'd2);
        dummy_n  = (kind == 3'd2) ? int'(req.dummy_cycles) : 0;
        rx_n     = reads ? int'(req.nbits) : 0;

        exp_bits = append_msb('0, {req.command, 24'h0}, CMD_W);
        tx_len   = CMD_W;
        if (has_addr) begin
            exp_bits = append_msb(exp_bits, {req.address, 8'h0}, ADDR_W);
            tx_len   = tx_len + ADDR_W;
        end
        if (writes) begin
            exp_bits = append_msb(exp_bits, req.data_in, int'(req.nbits));
            tx_len   = tx_len + int'(req.nbits);
        end
        periods  = tx_len + dummy_n + rx_n;
        exp_bits = exp_bits << (periods - tx_len);   // MOSI idles low after the header
        exp_dout = reads ? (stim[base+6] >> (32 - rx_n)) : 32'h0;

        assert (tx_len == int'(stim[base+7]) && exp_dout == stim[base+8]) else begin
            stim_errors++;
            $display("Stimulus line %0d disagrees with the frame rules", idx);
        end

        miso_word    = stim[base+6];
        skip_periods = 8'(tx_len + dummy_n);
        rx_bits      = 6'(rx_n);
        valid        = 1'b1;
        pulses_before = done_pulses;

        wait_level(SEL_SS, 1'b0, "chip select to fall", cycles, ok);
        if (!ok)
            return;
        assert (cycles == 3 && ready == 1'b0) else begin
            errors++;
            $display("ERR %0t: request %0d ss fell after %0d cycles, ready=%b",
                     $time, idx, cycles, ready);
        end

        wait_level(SEL_SS, 1'b1, "chip select to rise", cycles, ok);
        if (!ok)
            return;
        assert (cycles >= 2 * periods * CLKS_PER_HALF + 1
                && cycles <= 2 * periods * CLKS_PER_HALF + 2) else begin
            errors++;
            $display("ERR %0t: request %0d ss low for %0d cycles", $time, idx, cycles);
        end
        assert (int'(rec_cnt) == periods && rec_bits == exp_bits) else begin
            errors++;
            $display("ERR %0t: request %0d MOSI %0d bits %h, expected %0d bits %h",
                     $time, idx, rec_cnt, rec_bits, periods, exp_bits);
        end
        assert (int'(edge_cnt) == 2 * periods) else begin
            errors++;
            $display("ERR %0t: request %0d saw %0d sclk edges, expected %0d",
                     $time, idx, edge_cnt, 2 * periods);
        end
        assert (done == 1'b1 && ready == 1'b0 && data_out == exp_dout) else begin
            errors++;
            $display("ERR %0t: request %0d done=%b ready=%b data_out %h, expected %h",
                     $time, idx, done, ready, data_out, exp_dout);
        end

        wait_level(SEL_READY, 1'b1, "ready to return", cycles, ok);
        if (!ok)
            return;
        assert (cycles == 1) else begin
            errors++;
            $display("ERR %0t: request %0d ready rose %0d cycles after done",
                     $time, idx, cycles);
        end

        // No second frame may start while valid stays high
        ss_drops = 0;
        repeat (HOLD_CYCLES) begin
            tick();
            if (ss == 1'b0 || ready == 1'b0)
                ss_drops++;
        end
        assert (ss_drops == 0 && done_pulses - pulses_before == 1) else begin
            errors++;
            $display("ERR %0t: request %0d gave %0d done pulses, %0d busy cycles on hold",
                     $time, idx, done_pulses - pulses_before, ss_drops);
        end

        valid = 1'b0;
        tick();   // Valid must be seen low once before the next request
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[2:0]);
        repeat (gap) tick();
    endtask

    initial begin
        int idx;
        bit ok;

        errors       = 0;
        timeouts     = 0;
        stim_errors  = 0;
        done_pulses  = 0;
        rng_state    = 32'd19974;
        rst          = 1'b1;
        valid        = 1'b0;
        req          = '0;
        miso_word    = '0;
        skip_periods = '0;
        rx_bits      = '0;
        $readmemh("dv/spi_stimulus.txt", stim);

        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        tick();
        check_idle();

        idx = 0;
        ok  = 1'b1;
        while (ok && idx < MAX_REQ && stim[idx * FIELDS] != END_MARK) begin
            run_request(idx, ok);
            idx++;
        end
        if (idx == 0) begin
            stim_errors++;
            $display("No requests were read from the stimulus file");
        end

        $display("Requests %0d, value errors %0d, timeouts %0d, stimulus errors %0d",
                 idx, errors, timeouts, stim_errors);
        if (errors == 0 && timeouts == 0 && stim_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SPI flash master testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_spi_flash_master \
        -Mdir obj_dir \
        -f spi_flash_master.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_spi_flash_master)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$sim_output"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

/* source/spi_flash_master.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_flash_master #(
    parameter int CLKS_PER_HALF_SCLK = 2,
    parameter int CPOL               = 1,
    parameter int CPHA               = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  spi_flash_pkg::spi_req_t           req,
    input  logic                              valid,
    output logic                              ready,
    output logic                              done,
    output logic [spi_flash_pkg::DATA_W-1:0]  data_out,
    output logic                              sclk,
    output logic                              ss,
    output logic                              mosi,
    input  logic                              miso
);
    import spi_flash_pkg::*;

    logic              accept;
    logic              plan_valid;
    logic              idle;
    logic              start;
    logic              sclk_en;
    logic              frame_done;
    logic              lead_edge;
    logic              trail_edge;
    logic [DATA_W-1:0] rx_word;
    spi_plan_t         plan;

    spi_request_stage u_request (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .req        (req),
        .idle       (idle),
        .accept     (accept),
        .plan       (plan),
        .plan_valid (plan_valid)
    );

    spi_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .plan_valid (plan_valid),
        .frame_done (frame_done),
        .rx_word    (rx_word),
        .start      (start),
        .sclk_en    (sclk_en),
        .idle       (idle),
        .ss         (ss),
        .ready      (ready),
        .done       (done),
        .data_out   (data_out)
    );

    spi_sclk_gen #(
        .CLKS_PER_HALF_SCLK (CLKS_PER_HALF_SCLK),
        .CPOL               (CPOL)
    ) u_sclk_gen (
        .clk        (clk),
        .rst        (rst),
        .sclk_en    (sclk_en),
        .start      (start),
        .sclk_edges (plan.sclk_edges),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .frame_done (frame_done),
        .sclk       (sclk)
    );

    spi_shift_engine #(
        .CPHA (CPHA)
    ) u_shift (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .plan       (plan),
        .miso       (miso),
        .mosi       (mosi),
        .rx_word    (rx_word)
    );

endmodule

`default_nettype wire

/* source/spi_flash_pkg.sv */
`default_nettype none

package spi_flash_pkg;

    // Host side widths
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 24;   // 3-byte addressing only
    localparam int CMD_W   = 8;
    localparam int NBITS_W = 6;    // Data length, 1 to 32
    localparam int DUMMY_W = 4;

    // Frame planning widths
    localparam int FRAME_W  = CMD_W + ADDR_W + DATA_W;   // 64 bit transmit string
    localparam int TXBITS_W = 7;                         // Up to 64 bits on MOSI
    localparam int EDGE_W   = 8;                         // Max 158 sclk edges

    // Frame kinds, unknown codes fall back to command only
    typedef enum logic [2:0] {
        KIND_CMD            = 3'd0,
        KIND_CMD_READ       = 3'd1,
        KIND_CMD_ADDR_READ  = 3'd2,   // Only kind with dummy cycles
        KIND_CMD_WRITE      = 3'd3,
        KIND_CMD_ADDR_WRITE = 3'd4,
        KIND_CMD_ADDR       = 3'd5
    } spi_kind_t;

    // One host request
    typedef struct packed {
        spi_kind_t            kind;
        logic [CMD_W-1:0]     command;
        logic [ADDR_W-1:0]    address;
        logic [DATA_W-1:0]    data_in;       // Write data, top nbits are sent
        logic [NBITS_W-1:0]   nbits;
        logic [DUMMY_W-1:0]   dummy_cycles;
    } spi_req_t;

    // Frame plan shared by the datapath blocks
    typedef struct packed {
        logic [FRAME_W-1:0]   tx_frame;      // Left aligned, MSB first
        logic [TXBITS_W-1:0]  tx_bits;
        logic [DUMMY_W-1:0]   dummy;
        logic [NBITS_W-1:0]   rx_bits;       // 0 when nothing is read
        logic [EDGE_W-1:0]    sclk_edges;    // Two edges per bit period
    } spi_plan_t;

endpackage

`default_nettype wire

/* source/spi_request_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_request_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid,
    input  spi_flash_pkg::spi_req_t  req,
    input  logic                     idle,
    output logic                     accept,
    output spi_flash_pkg::spi_plan_t plan,
    output logic                     plan_valid
);
    import spi_flash_pkg::*;

    localparam int PER_W = EDGE_W - 1;   // Bit periods, doubled into edges

    logic             taken;     // This valid level was already consumed
    logic             take;
    spi_req_t         req_q;
    spi_plan_t        plan_d;
    logic [PER_W-1:0] periods;

    assign take = valid && !taken && idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taken      <= 1'b0;
            accept     <= 1'b0;
            plan_valid <= 1'b0;
        end else begin
            accept     <= take;
            plan_valid <= accept;   // Plan is ready one cycle after accept
            if (take)
                taken <= 1'b1;
            else if (!valid)
                taken <= 1'b0;      // Host dropped valid, arm for the next one
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            req_q <= req;
        if (accept)
            plan <= plan_d;
    end

    // Every frame starts with the command byte
    always_comb begin
        plan_d = '0;
        plan_d.tx_frame[FRAME_W-1 -: CMD_W] = req_q.command;
        plan_d.tx_bits = TXBITS_W'(CMD_W);
        case (req_q.kind)
            KIND_CMD_READ: begin
                plan_d.rx_bits = req_q.nbits;
            end
            KIND_CMD_ADDR_READ: begin
                plan_d.tx_frame[FRAME_W-CMD_W-1 -: ADDR_W] = req_q.address;
                plan_d.tx_bits = TXBITS_W'(CMD_W + ADDR_W);
                plan_d.dummy   = req_q.dummy_cycles;
                plan_d.rx_bits = req_q.nbits;
            end
            KIND_CMD_WRITE: begin
                plan_d.tx_frame[FRAME_W-CMD_W-1 -: DATA_W] = req_q.data_in;
                plan_d.tx_bits = TXBITS_W'(CMD_W) + TXBITS_W'(req_q.nbits);
            end
            KIND_CMD_ADDR_WRITE: begin
                plan_d.tx_frame[FRAME_W-CMD_W-1 -: ADDR_W] = req_q.address;
                plan_d.tx_frame[DATA_W-1:0]                = req_q.data_in;
                plan_d.tx_bits = TXBITS_W'(CMD_W + ADDR_W) + TXBITS_W'(req_q.nbits);
            end
            KIND_CMD_ADDR: begin
                plan_d.tx_frame[FRAME_W-CMD_W-1 -: ADDR_W] = req_q.address;
                plan_d.tx_bits = TXBITS_W'(CMD_W + ADDR_W);
            end
            default: ;   // Command only
        endcase
        periods = PER_W'(plan_d.tx_bits) + PER_W'(plan_d.dummy) + PER_W'(plan_d.rx_bits);
        plan_d.sclk_edges = {periods, 1'b0};
    end

endmodule

`default_nettype wire

/* source/spi_sclk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_sclk_gen #(
    parameter int CLKS_PER_HALF_SCLK = 2,
    parameter int CPOL               = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sclk_en,
    input  logic                              start,
    input  logic [spi_flash_pkg::EDGE_W-1:0]  sclk_edges,
    output logic                              lead_edge,
    output logic                              trail_edge,
    output logic                              frame_done,
    output logic                              sclk
);
    import spi_flash_pkg::*;

    localparam int               DIV_W      = (CLKS_PER_HALF_SCLK > 1) ?
                                              $clog2(CLKS_PER_HALF_SCLK) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(CLKS_PER_HALF_SCLK - 1);
    localparam logic             IDLE_LEVEL = (CPOL != 0);

    logic [DIV_W-1:0]  div_cnt;
    logic [DIV_W-1:0]  div_now;
    logic [EDGE_W-1:0] edge_cnt;
    logic [EDGE_W-1:0] edge_now;
    logic              sclk_int;
    logic              running;
    logic              half_done;

    // The start cycle already counts as the first clk of the half period
    assign div_now   = start ? '0 : div_cnt;
    assign edge_now  = start ? '0 : edge_cnt;
    assign half_done = (div_now == DIV_LAST);
    assign running   = start || (sclk_en && (edge_cnt != sclk_edges));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt    <= '0;
            edge_cnt   <= '0;
            sclk_int   <= IDLE_LEVEL;
            sclk       <= IDLE_LEVEL;
            lead_edge  <= 1'b0;
            trail_edge <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            lead_edge  <= 1'b0;
            trail_edge <= 1'b0;
            sclk       <= sclk_int;   // Pin lags the internal clock by one cycle
            frame_done <= sclk_en && !start && !frame_done && (edge_cnt == sclk_edges);
            if (running) begin
                if (half_done) begin
                    div_cnt    <= '0;
                    sclk_int   <= ~sclk_int;
                    edge_cnt   <= edge_now + 1'b1;
                    lead_edge  <= ~edge_now[0];   // Even edges lead
                    trail_edge <= edge_now[0];
                end else begin
                    div_cnt  <= div_now + 1'b1;
                    edge_cnt <= edge_now;   // Cleared on start
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/spi_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              accept,
    input  logic                              plan_valid,
    input  logic                              frame_done,
    input  logic [spi_flash_pkg::DATA_W-1:0]  rx_word,
    output logic                              start,
    output logic                              sclk_en,
    output logic                              idle,
    output logic                              ss,
    output logic                              ready,
    output logic                              done,
    output logic [spi_flash_pkg::DATA_W-1:0]  data_out
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,       // Waiting for the frame plan
        TRANSFER
    } state_t;

    state_t state;

    assign idle = (state == IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            start   <= 1'b0;
            sclk_en <= 1'b0;
            ss      <= 1'b1;
            ready   <= 1'b1;
            done    <= 1'b0;
        end else begin
            start <= 1'b0;
            done  <= 1'b0;
            case (state)
                IDLE: begin
                    ready <= !accept;   // Back high one cycle after done
                    if (accept)
                        state <= SETUP;
                end
                SETUP: begin
                    if (plan_valid) begin
                        start   <= 1'b1;
                        ss      <= 1'b0;   // Chip select drops with start
                        sclk_en <= 1'b1;
                        state   <= TRANSFER;
                    end
                end
                TRANSFER: begin
                    if (frame_done) begin
                        ss      <= 1'b1;
                        sclk_en <= 1'b0;
                        done    <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: begin
                    ss      <= 1'b1;
                    sclk_en <= 1'b0;
                    ready   <= 1'b1;
                    state   <= IDLE;
                end
            endcase
        end
    end

    // Result holds from done until the next accept
    always_ff @(posedge clk) begin
        if (idle && accept)
            data_out <= '0;
        else if (state == TRANSFER && frame_done)
            data_out <= rx_word;
    end

endmodule

`default_nettype wire

/* source/spi_shift_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_shift_engine #(
    parameter int CPHA = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic                              lead_edge,
    input  logic                              trail_edge,
    input  spi_flash_pkg::spi_plan_t          plan,
    input  logic                              miso,
    output logic                              mosi,
    output logic [spi_flash_pkg::DATA_W-1:0]  rx_word
);
    import spi_flash_pkg::*;

    localparam logic LAUNCH_ON_LEAD = (CPHA != 0);
    localparam int   SKIP_W         = TXBITS_W;   // tx_bits + dummy stays below 80

    logic                launch;
    logic                sample;
    logic                tx_more;
    logic                rx_take;
    logic [FRAME_W-1:0]  tx_sr;
    logic [TXBITS_W-1:0] tx_left;     // Bits still to launch
    logic [SKIP_W-1:0]   skip_left;   // Sample periods before read data
    logic [NBITS_W-1:0]  rx_left;

    assign launch  = LAUNCH_ON_LEAD ? lead_edge : trail_edge;
    assign sample  = LAUNCH_ON_LEAD ? trail_edge : lead_edge;
    assign tx_more = (tx_left != '0);
    assign rx_take = sample && (skip_left == '0) && (rx_left != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mosi      <= 1'b0;
            tx_left   <= '0;
            skip_left <= '0;
            rx_left   <= '0;
        end else if (start) begin
            skip_left <= SKIP_W'(plan.tx_bits) + SKIP_W'(plan.dummy);
            rx_left   <= plan.rx_bits;
            if (LAUNCH_ON_LEAD) begin
                mosi    <= 1'b0;
                tx_left <= plan.tx_bits;
            end else begin
                mosi    <= plan.tx_frame[FRAME_W-1];   // First bit out before any edge
                tx_left <= plan.tx_bits - 1'b1;
            end
        end else begin
            if (launch) begin
                mosi <= tx_more ? tx_sr[FRAME_W-1] : 1'b0;
                if (tx_more)
                    tx_left <= tx_left - 1'b1;
            end
            if (sample) begin
                if (skip_left != '0)
                    skip_left <= skip_left - 1'b1;
                else if (rx_left != '0)
                    rx_left <= rx_left - 1'b1;
            end
        end
    end

    // Transmit and receive shift registers
    always_ff @(posedge clk) begin
        if (start) begin
            tx_sr   <= LAUNCH_ON_LEAD ? plan.tx_frame
                                      : {plan.tx_frame[FRAME_W-2:0], 1'b0};
            rx_word <= '0;
        end else begin
            if (launch && tx_more)
                tx_sr <= {tx_sr[FRAME_W-2:0], 1'b0};
            if (rx_take)
                rx_word <= {rx_word[DATA_W-2:0], miso};   // Ends right aligned
        end
    end

endmodule

`default_nettype wire

/* spi_flash_master.f */
source/spi_flash_pkg.sv
source/spi_request_stage.sv
source/spi_sequencer.sv
source/spi_sclk_gen.sv
source/spi_shift_engine.sv
source/spi_flash_master.sv
dv/spi_flash_model.sv
dv/tb_spi_flash_master.sv
